/* project.f */
source/dcache_pkg.sv
source/dcache_request_decode.sv
source/dcache_mem.sv
source/dcache_miss_control.sv
source/dcache_response.sv
source/dcache_top.sv
verification/dcache_assert.sv
verification/dcache_tb.sv

/* source/dcache_mem.sv */
`timescale 1ns/1ps

module dcache_mem (
	input logic clock,
	input logic reset,
	input logic lookup_valid,
	input logic lookup_store,
	input dcache_pkg::dcache_index_t lookup_index,
	input dcache_pkg::dcache_tag_t lookup_tag,
	input dcache_pkg::dcache_block_t lookup_data,
	input logic refill_start,
	input dcache_pkg::mem_tag_t refill_tag,
	input dcache_pkg::mem_tag_t mem_tag,
	input dcache_pkg::dcache_block_t mem_load_data,
	output logic hit,
	output logic victim_dirty,
	output dcache_pkg::dcache_addr_t victim_addr,
	output dcache_pkg::dcache_block_t victim_data,
	output dcache_pkg::dcache_block_t read_data,
	output logic fill_done
);

	// block and tag storage
	dcache_pkg::dcache_block_t data_array [dcache_pkg::DCACHE_SETS][dcache_pkg::DCACHE_WAYS];
	dcache_pkg::dcache_tag_t tag_array [dcache_pkg::DCACHE_SETS][dcache_pkg::DCACHE_WAYS];

	// memory tag we are waiting on, per line
	dcache_pkg::mem_tag_t pend_tag [dcache_pkg::DCACHE_SETS][dcache_pkg::DCACHE_WAYS];

	// line state
	logic [dcache_pkg::DCACHE_SETS-1:0][dcache_pkg::DCACHE_WAYS-1:0] valid;
	logic [dcache_pkg::DCACHE_SETS-1:0][dcache_pkg::DCACHE_WAYS-1:0] dirty;
	logic [dcache_pkg::DCACHE_SETS-1:0][dcache_pkg::DCACHE_WAYS-1:0] pending;
	// pending miss came from a store
	logic [dcache_pkg::DCACHE_SETS-1:0][dcache_pkg::DCACHE_WAYS-1:0] pend_store;

	// one bit per set, names the way to evict next
	logic [dcache_pkg::DCACHE_SETS-1:0] lru;

	logic [dcache_pkg::DCACHE_WAYS-1:0] way_match;
	logic [dcache_pkg::DCACHE_WAYS-1:0] fill_match;
	logic hit_way;
	logic fill_way;
	logic victim_way;
	dcache_pkg::dcache_block_t fill_block;

	// tag compare and fill match, both ways of the held set
	always_comb
	begin
		for (int w = 0; w < dcache_pkg::DCACHE_WAYS; w++)
		begin
			way_match[w] = valid[lookup_index][w]
				&& (tag_array[lookup_index][w] == lookup_tag);
			fill_match[w] = pending[lookup_index][w] && (mem_tag != '0)
				&& (pend_tag[lookup_index][w] == mem_tag);
		end
	end

	assign hit = |way_match;
	assign hit_way = way_match[1];
	assign fill_done = |fill_match;
	assign fill_way = fill_match[1];

	// victim is whatever the LRU bit points at
	assign victim_way = lru[lookup_index];
	assign victim_dirty = valid[lookup_index][victim_way] & dirty[lookup_index][victim_way];
	assign victim_addr = {tag_array[lookup_index][victim_way], lookup_index};
	assign victim_data = data_array[lookup_index][victim_way];

	// store misses take the core data, load misses the memory word
	assign fill_block = pend_store[lookup_index][fill_way] ? lookup_data : mem_load_data;

	// a store returns what it wrote
	always_comb
	begin
		if (fill_done)
		begin
			read_data = fill_block;
		end
		else if (lookup_store)
		begin
			read_data = lookup_data;
		end
		else
		begin
			read_data = data_array[lookup_index][hit_way];
		end
	end

	// valid, dirty, pending and LRU
	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			valid <= '0;
			dirty <= '0;
			pending <= '0;
			lru <= '0;
		end
		else
		begin
			if (lookup_valid && hit)
			begin
				lru[lookup_index] <= ~hit_way;
				if (lookup_store)
				begin
					dirty[lookup_index][hit_way] <= 1'b1;
				end
			end
			// line is claimed for the refill, old contents already written back
			if (refill_start)
			begin
				valid[lookup_index][victim_way] <= 1'b0;
				dirty[lookup_index][victim_way] <= 1'b0;
				pending[lookup_index][victim_way] <= 1'b1;
			end
			if (fill_done)
			begin
				valid[lookup_index][fill_way] <= 1'b1;
				dirty[lookup_index][fill_way] <= pend_store[lookup_index][fill_way];
				pending[lookup_index][fill_way] <= 1'b0;
				lru[lookup_index] <= ~fill_way;
			end
		end
	end

	// block, tag and miss bookkeeping
	always_ff @(posedge clock)
	begin
		if (lookup_valid && hit && lookup_store)
		begin
			data_array[lookup_index][hit_way] <= lookup_data;
		end
		if (refill_start)
		begin
			tag_array[lookup_index][victim_way] <= lookup_tag;
			pend_tag[lookup_index][victim_way] <= refill_tag;
			pend_store[lookup_index][victim_way] <= lookup_store;
		end
		if (fill_done)
		begin
			data_array[lookup_index][fill_way] <= fill_block;
		end
	end

endmodule

/* source/dcache_miss_control.sv */
`timescale 1ns/1ps

module dcache_miss_control (
	input logic clock,
	input logic reset,
	input logic lookup_valid,
	input logic hit,
	input logic victim_dirty,
	input dcache_pkg::dcache_addr_t victim_addr,
	input dcache_pkg::dcache_block_t victim_data,
	input logic fill_done,
	input dcache_pkg::dcache_index_t lookup_index,
	input dcache_pkg::dcache_tag_t lookup_tag,
	input dcache_pkg::mem_tag_t mem_response,
	output dcache_pkg::mem_command_t mem_command,
	output dcache_pkg::dcache_addr_t mem_addr,
	output dcache_pkg::dcache_block_t mem_store_data,
	output logic refill_start,
	output dcache_pkg::mem_tag_t refill_tag,
	output logic complete
);

	typedef enum logic [1:0]
	{
		idle,
		writeback,
		refill,
		wait_fill
	} state_t;

	state_t state;
	state_t state_next;

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			state <= idle;
		end
		else
		begin
			state <= state_next;
		end
	end

	always_comb
	begin
		state_next = state;
		case (state)
			idle:
			begin
				if (lookup_valid && !hit)
				begin
					state_next = victim_dirty ? writeback : refill;
				end
			end
			writeback:
			begin
				state_next = refill;
			end
			refill:
			begin
				state_next = wait_fill;
			end
			wait_fill:
			begin
				if (fill_done)
				begin
					state_next = idle;
				end
			end
			default:
			begin
				state_next = idle;
			end
		endcase
	end

	// one memory command per cycle, writeback always ahead of refill
	always_comb
	begin
		mem_command = dcache_pkg::MEM_NONE;
		mem_addr = {lookup_tag, lookup_index};
		mem_store_data = '0;
		if (state == writeback)
		begin
			mem_command = dcache_pkg::MEM_STORE;
			mem_addr = victim_addr;
			mem_store_data = victim_data;
		end
		else if (state == refill)
		begin
			mem_command = dcache_pkg::MEM_LOAD;
		end
	end

	// tag comes back in the same cycle as the load command
	assign refill_start = (state == refill);
	assign refill_tag = mem_response;

	assign complete = ((state == idle) && lookup_valid && hit)
		|| ((state == wait_fill) && fill_done);

endmodule

/* source/dcache_pkg.sv */
package dcache_pkg;

	// cache geometry
	localparam int DCACHE_SETS = 16;
	localparam int DCACHE_WAYS = 2;

	// address split, tag on top and set index below
	localparam int DCACHE_INDEX_BITS = 4;
	localparam int DCACHE_TAG_BITS = 9;
	localparam int DCACHE_ADDR_BITS = DCACHE_TAG_BITS + DCACHE_INDEX_BITS;

	// one block is one memory word
	localparam int DCACHE_BLOCK_BITS = 64;

	// memory transaction tag, zero is reserved for "no tag"
	localparam int MEM_TAG_BITS = 4;
	localparam int MEM_COMMAND_BITS = 2;

	typedef logic [DCACHE_BLOCK_BITS-1:0] dcache_block_t;
	typedef logic [DCACHE_ADDR_BITS-1:0] dcache_addr_t;
	typedef logic [DCACHE_INDEX_BITS-1:0] dcache_index_t;
	typedef logic [DCACHE_TAG_BITS-1:0] dcache_tag_t;
	typedef logic [MEM_TAG_BITS-1:0] mem_tag_t;
	typedef logic [MEM_COMMAND_BITS-1:0] mem_command_t;

	// memory command codes
	localparam mem_command_t MEM_NONE = 2'd0;
	localparam mem_command_t MEM_LOAD = 2'd1;
	localparam mem_command_t MEM_STORE = 2'd2;

endpackage

/* source/dcache_request_decode.sv */
`timescale 1ns/1ps

module dcache_request_decode (
	input logic clock,
	input logic reset,
	input logic req_valid,
	input logic req_store,
	input dcache_pkg::dcache_addr_t req_addr,
	input dcache_pkg::dcache_block_t req_data,
	input logic resp_valid,
	output logic lookup_valid,
	output logic lookup_store,
	output dcache_pkg::dcache_index_t lookup_index,
	output dcache_pkg::dcache_tag_t lookup_tag,
	output dcache_pkg::dcache_block_t lookup_data,
	output logic busy
);

	// strobe and busy flag
	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			lookup_valid <= 1'b0;
			busy <= 1'b0;
		end
		else
		begin
			lookup_valid <= req_valid;
			if (req_valid)
			begin
				busy <= 1'b1;
			end
			else if (resp_valid)
			begin
				busy <= 1'b0;
			end
		end
	end

	// request fields stay put until the next request,
	// so the array sees one set for the whole miss
	always_ff @(posedge clock)
	begin
		if (req_valid)
		begin
			lookup_store <= req_store;
			lookup_index <= req_addr[dcache_pkg::DCACHE_INDEX_BITS-1:0];
			lookup_tag <= req_addr[dcache_pkg::DCACHE_ADDR_BITS-1:dcache_pkg::DCACHE_INDEX_BITS];
			lookup_data <= req_data;
		end
	end

endmodule

/* source/dcache_response.sv */
`timescale 1ns/1ps

module dcache_response (
	input logic clock,
	input logic reset,
	input logic complete,
	input dcache_pkg::dcache_block_t read_data,
	output logic resp_valid,
	output dcache_pkg::dcache_block_t resp_data
);

	// one-cycle strobe back to the core
	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			resp_valid <= 1'b0;
		end
		else
		begin
			resp_valid <= complete;
		end
	end

	// data is only sampled on completion
	always_ff @(posedge clock)
	begin
		if (complete)
		begin
			resp_data <= read_data;
		end
	end

endmodule

/* source/dcache_top.sv */
`timescale 1ns/1ps

module dcache_top (
	input logic clock,
	input logic reset,
	// core side
	input logic req_valid,
	input logic req_store,
	input dcache_pkg::dcache_addr_t req_addr,
	input dcache_pkg::dcache_block_t req_data,
	output logic busy,
	output logic resp_valid,
	output dcache_pkg::dcache_block_t resp_data,
	// memory side
	output dcache_pkg::mem_command_t mem_command,
	output dcache_pkg::dcache_addr_t mem_addr,
	output dcache_pkg::dcache_block_t mem_store_data,
	input dcache_pkg::mem_tag_t mem_response,
	input dcache_pkg::mem_tag_t mem_tag,
	input dcache_pkg::dcache_block_t mem_load_data
);

	logic lookup_valid;
	logic lookup_store;
	dcache_pkg::dcache_index_t lookup_index;
	dcache_pkg::dcache_tag_t lookup_tag;
	dcache_pkg::dcache_block_t lookup_data;
	logic hit;
	logic victim_dirty;
	dcache_pkg::dcache_addr_t victim_addr;
	dcache_pkg::dcache_block_t victim_data;
	dcache_pkg::dcache_block_t read_data;
	logic fill_done;
	logic refill_start;
	dcache_pkg::mem_tag_t refill_tag;
	logic complete;

	dcache_request_decode u_decode (
		.clock(clock),
		.reset(reset),
		.req_valid(req_valid),
		.req_store(req_store),
		.req_addr(req_addr),
		.req_data(req_data),
		.resp_valid(resp_valid),
		.lookup_valid(lookup_valid),
		.lookup_store(lookup_store),
		.lookup_index(lookup_index),
		.lookup_tag(lookup_tag),
		.lookup_data(lookup_data),
		.busy(busy)
	);

	dcache_mem u_mem (
		.clock(clock),
		.reset(reset),
		.lookup_valid(lookup_valid),
		.lookup_store(lookup_store),
		.lookup_index(lookup_index),
		.lookup_tag(lookup_tag),
		.lookup_data(lookup_data),
		.refill_start(refill_start),
		.refill_tag(refill_tag),
		.mem_tag(mem_tag),
		.mem_load_data(mem_load_data),
		.hit(hit),
		.victim_dirty(victim_dirty),
		.victim_addr(victim_addr),
		.victim_data(victim_data),
		.read_data(read_data),
		.fill_done(fill_done)
	);

	dcache_miss_control u_miss (
		.clock(clock),
		.reset(reset),
		.lookup_valid(lookup_valid),
		.hit(hit),
		.victim_dirty(victim_dirty),
		.victim_addr(victim_addr),
		.victim_data(victim_data),
		.fill_done(fill_done),
		.lookup_index(lookup_index),
		.lookup_tag(lookup_tag),
		.mem_response(mem_response),
		.mem_command(mem_command),
		.mem_addr(mem_addr),
		.mem_store_data(mem_store_data),
		.refill_start(refill_start),
		.refill_tag(refill_tag),
		.complete(complete)
	);

	dcache_response u_response (
		.clock(clock),
		.reset(reset),
		.complete(complete),
		.read_data(read_data),
		.resp_valid(resp_valid),
		.resp_data(resp_data)
	);

endmodule

/* verification/dcache_assert.sv */
`timescale 1ns/1ps

module dcache_assert (
	input logic clock,
	input logic reset,
	input logic req_valid,
	input logic req_store,
	input dcache_pkg::dcache_block_t req_data,
	input logic busy,
	input logic resp_valid,
	input dcache_pkg::dcache_block_t resp_data,
	input dcache_pkg::mem_command_t mem_command,
	input dcache_pkg::mem_tag_t mem_response,
	input dcache_pkg::mem_tag_t mem_tag,
	input logic hit
);

	int error_count = 0;

	// quiet outputs once reset has been seen
	a_reset_idle: assert property (@(posedge clock) reset |=> (!resp_valid && !busy
		&& mem_command == dcache_pkg::MEM_NONE))
	else
	begin
		error_count++;
		$error("cache outputs not idle after reset");
	end

	// core may only send while the cache is free
	a_core_rule: assert property (@(posedge clock) disable iff (reset)
		req_valid |-> !busy)
	else
	begin
		error_count++;
		$error("request sent while busy");
	end

	a_resp_strobe: assert property (@(posedge clock) disable iff (reset)
		resp_valid |=> !resp_valid)
	else
	begin
		error_count++;
		$error("resp_valid held longer than one cycle");
	end

	// memory answers every command with a real tag
	a_mem_response: assert property (@(posedge clock) disable iff (reset)
		(mem_command != dcache_pkg::MEM_NONE) |-> (mem_response != '0 && busy))
	else
	begin
		error_count++;
		$error("memory command outside a request or without a response tag");
	end

	// writeback is always followed by the refill, and the refill by silence
	a_writeback_order: assert property (@(posedge clock) disable iff (reset)
		(mem_command == dcache_pkg::MEM_STORE) |=> (mem_command == dcache_pkg::MEM_LOAD))
	else
	begin
		error_count++;
		$error("writeback not followed by the refill load");
	end

	a_single_load: assert property (@(posedge clock) disable iff (reset)
		(mem_command == dcache_pkg::MEM_LOAD) |=> (mem_command == dcache_pkg::MEM_NONE))
	else
	begin
		error_count++;
		$error("refill load issued for more than one cycle");
	end

	// a hit answers two edges after the request
	a_hit_latency: assert property (@(posedge clock) disable iff (reset)
		req_valid ##1 hit |=> resp_valid)
	else
	begin
		error_count++;
		$error("hit response not two edges after the request");
	end

	a_store_data: assert property (@(posedge clock) disable iff (reset)
		(req_valid && req_store) ##1 hit |=> (resp_data == $past(req_data, 2)))
	else
	begin
		error_count++;
		$error("store response does not return the stored block");
	end

	// returned load tag ends the miss one edge later
	a_fill_response: assert property (@(posedge clock) disable iff (reset)
		(mem_tag != '0) |=> resp_valid)
	else
	begin
		error_count++;
		$error("load data from memory did not complete the request");
	end

	a_resp_known: assert property (@(posedge clock) disable iff (reset)
		resp_valid |-> !$isunknown(resp_data))
	else
	begin
		error_count++;
		$error("response data unknown");
	end

endmodule

/* verification/dcache_tb.sv */
`timescale 1ns/1ps

module dcache_tb;

	localparam int RESPONSE_TIMEOUT = 60;

	logic clock;
	logic reset;
	logic req_valid;
	logic req_store;
	dcache_pkg::dcache_addr_t req_addr;
	dcache_pkg::dcache_block_t req_data;
	logic busy;
	logic resp_valid;
	dcache_pkg::dcache_block_t resp_data;
	dcache_pkg::mem_command_t mem_command;
	dcache_pkg::dcache_addr_t mem_addr;
	dcache_pkg::dcache_block_t mem_store_data;
	dcache_pkg::mem_tag_t mem_response;
	dcache_pkg::mem_tag_t mem_tag;
	dcache_pkg::dcache_block_t mem_load_data;

	logic [31:0] lfsr;

	// memory model state
	dcache_pkg::dcache_block_t backing [dcache_pkg::dcache_addr_t];
	dcache_pkg::mem_tag_t load_tag;
	dcache_pkg::dcache_block_t load_data;
	int load_wait;
	logic advance_tag;
	logic fire_tag;

	// memory commands seen during the current access
	dcache_pkg::mem_command_t command_log [$];
	dcache_pkg::dcache_addr_t addr_log [$];
	dcache_pkg::dcache_block_t data_log [$];

	// every block the core has stored
	dcache_pkg::dcache_block_t shadow [dcache_pkg::dcache_addr_t];

	dcache_top u_dut (
		.clock(clock),
		.reset(reset),
		.req_valid(req_valid),
		.req_store(req_store),
		.req_addr(req_addr),
		.req_data(req_data),
		.busy(busy),
		.resp_valid(resp_valid),
		.resp_data(resp_data),
		.mem_command(mem_command),
		.mem_addr(mem_addr),
		.mem_store_data(mem_store_data),
		.mem_response(mem_response),
		.mem_tag(mem_tag),
		.mem_load_data(mem_load_data)
	);

	bind dcache_top dcache_assert u_assert (.*);

	initial
	begin
		clock = 1'b0;
		forever
		begin
			#4 clock = ~clock;
		end
	end

	// right-shifting galois form
	function automatic logic [31:0] lfsr_next(input logic [31:0] state);
		if (state[0])
		begin
			return (state >> 1) ^ 32'h8020_0003;
		end
		return state >> 1;
	endfunction

	function automatic logic [31:0] rand_bits(input int count);
		logic [31:0] value;
		value = '0;
		for (int i = 0; i < count; i++)
		begin
			lfsr = lfsr_next(lfsr);
			value = {value[30:0], lfsr[0]};
		end
		return value;
	endfunction

	// never-written words read back as their own address
	function automatic dcache_pkg::dcache_block_t pattern_for(input dcache_pkg::dcache_addr_t a);
		return {a[11:0], a, a, a, a};
	endfunction

	function automatic dcache_pkg::dcache_addr_t make_addr(input int tag, input int index);
		return dcache_pkg::dcache_addr_t'(tag * dcache_pkg::DCACHE_SETS + index);
	endfunction

	task automatic stop_with_failure();
		$display("tests failed");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic check_value(input string name, input logic [63:0] expected,
		input logic [63:0] actual);
		assert (actual === expected)
		else
		begin
			$display("error at %0t: %s expected %h, got %h", $time, name, expected, actual);
			stop_with_failure();
		end
	endtask

	task automatic expect_command_count(input int count);
		check_value("memory command count", count, command_log.size());
	endtask

	task automatic expect_command(input int slot, input dcache_pkg::mem_command_t command,
		input dcache_pkg::dcache_addr_t addr);
		check_value("mem_command", command, command_log[slot]);
		check_value("mem_addr", addr, addr_log[slot]);
	endtask

	// resident block answers with fixed latency and no memory traffic
	task automatic check_hit(input int latency);
		check_value("hit latency", 2, latency);
		expect_command_count(0);
	endtask

	// one core request entered and left 1 ns after a rising edge
	task automatic access(input logic store, input dcache_pkg::dcache_addr_t addr,
		input dcache_pkg::dcache_block_t data, output int latency);
		dcache_pkg::dcache_block_t expected;
		if (store)
		begin
			shadow[addr] = data;
		end
		expected = shadow.exists(addr) ? shadow[addr] : pattern_for(addr);
		command_log.delete();
		addr_log.delete();
		data_log.delete();
		req_valid = 1'b1;
		req_store = store;
		req_addr = addr;
		req_data = data;
		@(posedge clock);
		#1;
		req_valid = 1'b0;
		// the edge that takes the request counts as the first
		latency = 1;
		while (!resp_valid)
		begin
			if (latency >= RESPONSE_TIMEOUT)
			begin
				$display("no response within %0d cycles for address %h",
					RESPONSE_TIMEOUT, addr);
				stop_with_failure();
			end
			else
			begin
				@(posedge clock);
				#1;
				latency++;
			end
		end
		check_value("resp_data", expected, resp_data);
		@(posedge clock);
		#1;
	endtask

	// tagged memory sampled on the edge and driven 1 ns later
	always @(posedge clock)
	begin
		advance_tag = 1'b0;
		fire_tag = 1'b0;
		if (!reset && mem_command != dcache_pkg::MEM_NONE)
		begin
			advance_tag = 1'b1;
			command_log.push_back(mem_command);
			addr_log.push_back(mem_addr);
			data_log.push_back(mem_store_data);
			if (mem_command == dcache_pkg::MEM_STORE)
			begin
				backing[mem_addr] = mem_store_data;
			end
			else
			begin
				load_tag = mem_response;
				load_data = backing.exists(mem_addr) ? backing[mem_addr] : pattern_for(mem_addr);
				load_wait = 2 + int'(rand_bits(3));
			end
		end
		else if (load_wait > 0)
		begin
			load_wait--;
			fire_tag = (load_wait == 0);
		end
		#1;
		if (advance_tag)
		begin
			mem_response = (mem_response == 4'd15) ? 4'd1 : mem_response + 4'd1;
		end
		mem_tag = fire_tag ? load_tag : '0;
		mem_load_data = load_data;
	end

	always @(posedge clock)
	begin
		if (u_dut.u_assert.error_count != 0)
		begin
			$display("a bound assertion failed, see the message above");
			stop_with_failure();
		end
	end

	initial
	begin
		int latency;
		int tag_pick;
		int set_pick;
		logic store_op;
		dcache_pkg::dcache_addr_t a;
		dcache_pkg::dcache_addr_t b;
		dcache_pkg::dcache_addr_t c;
		dcache_pkg::dcache_block_t data;

		lfsr = 32'h32b9_ca9f;
		reset = 1'b1;
		req_valid = 1'b0;
		req_store = 1'b0;
		req_addr = '0;
		req_data = '0;
		mem_response = 4'd1;
		mem_tag = '0;
		mem_load_data = '0;
		load_tag = '0;
		load_data = '0;
		load_wait = 0;
		repeat (16) @(posedge clock);
		#1;
		reset = 1'b0;

		// nothing requested yet
		repeat (4)
		begin
			@(posedge clock);
			#1;
			check_value("resp_valid", 0, resp_valid);
			check_value("busy", 0, busy);
			check_value("mem_command", dcache_pkg::MEM_NONE, mem_command);
		end

		// cold miss followed by hits on the same block
		a = make_addr(9'h012, 3);
		access(1'b0, a, '0, latency);
		expect_command_count(1);
		expect_command(0, dcache_pkg::MEM_LOAD, a);
		access(1'b0, a, '0, latency);
		check_hit(latency);
		access(1'b1, a, 64'h0123_4567_89ab_cdef, latency);
		check_hit(latency);
		access(1'b0, a, '0, latency);
		check_hit(latency);

		// three dirty tags in one set force writebacks
		a = make_addr(9'h020, 5);
		b = make_addr(9'h021, 5);
		c = make_addr(9'h022, 5);
		access(1'b1, a, 64'haaaa_5555_0000_0005, latency);
		access(1'b1, b, 64'hbbbb_4444_1111_0005, latency);
		access(1'b1, c, 64'hcccc_3333_2222_0005, latency);
		expect_command_count(2);
		expect_command(0, dcache_pkg::MEM_STORE, a);
		check_value("mem_store_data", shadow[a], data_log[0]);
		expect_command(1, dcache_pkg::MEM_LOAD, c);
		// b is now the older line and dirty
		access(1'b0, a, '0, latency);
		expect_command_count(2);
		expect_command(0, dcache_pkg::MEM_STORE, b);
		check_value("mem_store_data", shadow[b], data_log[0]);
		expect_command(1, dcache_pkg::MEM_LOAD, a);

		// touching a again protects it from the next eviction
		a = make_addr(9'h030, 7);
		b = make_addr(9'h031, 7);
		c = make_addr(9'h032, 7);
		access(1'b0, a, '0, latency);
		access(1'b0, b, '0, latency);
		access(1'b0, a, '0, latency);
		check_hit(latency);
		access(1'b0, c, '0, latency);
		expect_command_count(1);
		expect_command(0, dcache_pkg::MEM_LOAD, c);
		access(1'b0, a, '0, latency);
		check_hit(latency);
		access(1'b0, b, '0, latency);
		expect_command_count(1);
		expect_command(0, dcache_pkg::MEM_LOAD, b);

		// random loads and stores over 4 sets and 6 tags
		for (int i = 0; i < 200; i++)
		begin
			store_op = (rand_bits(1) != 0);
			set_pick = int'(rand_bits(2));
			tag_pick = int'(rand_bits(3)) % 6;
			data[63:32] = rand_bits(32);
			data[31:0] = rand_bits(32);
			a = make_addr(9'h100 + tag_pick, (8 + set_pick) % dcache_pkg::DCACHE_SETS);
			access(store_op, a, data, latency);
		end

		repeat (4) @(posedge clock);
		if (u_dut.u_assert.error_count == 0)
		begin
			$display("all tests passed");
			$finish;
		end
		else
		begin
			stop_with_failure();
		end
	end

endmodule
